//--- verilog/usb_regs_pkg.sv
package usb_regs_pkg;

    // word indices of the register map
    typedef enum logic [1:0] {
        REG_CCR     = 2'd0,
        REG_FRAME   = 2'd1,
        REG_SCRATCH = 2'd2,
        REG_STA     = 2'd3
    } reg_idx_e;

    localparam int unsigned DEF_SIZE = 4;
    localparam logic [3:0] DEF_ALLOW_WRITE = 4'b1101; // frame counter read-only on the bus

    // control register fields
    typedef struct packed {
        logic [28:0] rsvd;
        logic        irq_en;
        logic        clr;    // self-clearing
        logic        en;
    } ccr_t;

    typedef union packed {
        logic [31:0] raw;
        ccr_t        ccr;
    } reg_word_u;

    // processor bus request
    typedef struct packed {
        logic        we;
        logic [3:0]  be;
        logic [31:0] addr;  // byte address
        logic [31:0] wdata;
    } bus_req_t;

    // decoded bus write toward the register file
    typedef struct packed {
        logic [3:0]  wen;   // one per register
        logic [31:0] mask;  // byte enables spread to bits
        logic [31:0] data;
    } bus_wr_t;

    // engine-side whole-word write
    typedef struct packed {
        logic        we;
        logic [1:0]  idx;
        logic [31:0] data;
    } perip_wr_t;

endpackage

//--- verilog/usb_bus_port.sv
`timescale 1ns/1ps

module usb_bus_port import usb_regs_pkg::*; #(
    parameter int unsigned          SIZE        = DEF_SIZE,
    parameter logic [SIZE-1:0]      ALLOW_WRITE = DEF_ALLOW_WRITE
) (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  bus_req_t   bus_i,
    output bus_wr_t    wr_o,
    output logic [1:0] rd_idx_o,
    output logic       rd_valid_o,
    output logic       bus_err_o
);

    logic [29:0] word_addr;
    logic        in_range;
    logic        err_q;

    assign word_addr = bus_i.addr[31:2];
    assign in_range  = (word_addr < 30'(SIZE));

    assign rd_idx_o   = word_addr[1:0];
    assign rd_valid_o = in_range;

    // read-only registers never see a bus write
    always_comb begin
        wr_o.wen = '0;
        for (int i = 0; i < SIZE; i++) begin
            wr_o.wen[i] = bus_i.we && in_range && ALLOW_WRITE[i] && (word_addr[1:0] == 2'(i));
        end
    end

    assign wr_o.mask = {{8{bus_i.be[3]}}, {8{bus_i.be[2]}},
                        {8{bus_i.be[1]}}, {8{bus_i.be[0]}}};
    assign wr_o.data = bus_i.wdata;

    // sticky until reset
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            err_q <= 1'b0;
        end else if (bus_i.we && !in_range) begin
            err_q <= 1'b1;
        end
    end

    assign bus_err_o = err_q;

endmodule

//--- verilog/usb_sof_engine.sv
`timescale 1ns/1ps

module usb_sof_engine import usb_regs_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        sof_i,
    input  ccr_t        ccr_nxt_i,
    input  logic        sta_1_i,
    input  logic [31:0] frame_i,
    output perip_wr_t   perip_o,
    output logic [1:0]  rd_idx_o,
    output logic        irq_o
);

    typedef enum logic {
        ST_IDLE,
        ST_CLR_WB   // write control word back with clear dropped
    } state_e;

    state_e    state_q;
    state_e    state_nxt;
    ccr_t      ccr_q;
    reg_word_u wb_word;
    logic      irq_q;

    // local copy tracks the stored control register
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ccr_q <= '0;
        end else begin
            ccr_q <= ccr_nxt_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_nxt;
        end
    end

    always_comb begin
        wb_word         = '0;
        wb_word.ccr     = ccr_q;
        wb_word.ccr.clr = 1'b0;
    end

    always_comb begin
        state_nxt    = state_q;
        perip_o.we   = 1'b0;
        perip_o.idx  = REG_FRAME;
        perip_o.data = '0;

        case (state_q)
            ST_IDLE: begin
                if (ccr_q.clr) begin
                    // first clear step ignores sof
                    perip_o.we   = 1'b1;
                    perip_o.idx  = REG_FRAME;
                    perip_o.data = '0;
                    state_nxt    = ST_CLR_WB;
                end else if (ccr_q.en && sof_i) begin
                    perip_o.we   = 1'b1;
                    perip_o.idx  = REG_FRAME;
                    perip_o.data = frame_i + 32'd1;
                end
            end
            ST_CLR_WB: begin
                perip_o.we   = 1'b1;
                perip_o.idx  = REG_CCR;
                perip_o.data = wb_word.raw; // a bus write this cycle still wins in the regfile
                state_nxt    = ST_IDLE;
            end
            default: begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

    assign rd_idx_o = REG_FRAME;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            irq_q <= 1'b0;
        end else begin
            irq_q <= ccr_q.irq_en & sta_1_i;
        end
    end

    assign irq_o = irq_q;

endmodule

//--- verilog/usb_mem.sv
`timescale 1ns/1ps

module usb_mem import usb_regs_pkg::*; #(
    parameter int unsigned     SIZE        = DEF_SIZE,
    parameter logic [SIZE-1:0] ALLOW_WRITE = DEF_ALLOW_WRITE
) (
    input  logic        clk_i,
    input  logic        rst_n_i,

    input  bus_wr_t     bus_wr_i,
    input  logic [1:0]  bus_rd_idx_i,
    input  logic        bus_rd_valid_i,
    output logic [31:0] bus_rdata_o,

    input  perip_wr_t   perip_i,
    input  logic [1:0]  perip_rd_idx_i,
    output logic [31:0] perip_rdata_o,

    output ccr_t        ccr_nxt_o,
    input  logic [1:0]  sta_i,
    output logic        sta_1_o
);

    reg_word_u mem_q   [SIZE];
    reg_word_u mem_nxt [SIZE];
    logic [SIZE-1:0] bus_wen;
    logic [SIZE-1:0] perip_wen;

    always_comb begin
        for (int i = 0; i < SIZE; i++) begin
            bus_wen[i]   = bus_wr_i.wen[i] & ALLOW_WRITE[i];
            perip_wen[i] = perip_i.we && (perip_i.idx == 2'(i));
        end
    end

    // engine word first, then the status sample, then bus bytes on top
    always_comb begin
        for (int i = 0; i < SIZE; i++) begin
            mem_nxt[i] = mem_q[i];
            if (perip_wen[i]) begin
                mem_nxt[i].raw = perip_i.data;
            end
            if (i == int'(REG_STA)) begin
                mem_nxt[i].raw = {30'b0, sta_i}; // sampled every cycle
            end
            if (bus_wen[i]) begin
                mem_nxt[i].raw = (mem_nxt[i].raw & ~bus_wr_i.mask)
                               | (bus_wr_i.data & bus_wr_i.mask);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < SIZE; i++) begin
                mem_q[i] <= '0;
            end
        end else begin
            mem_q <= mem_nxt;
        end
    end

    assign ccr_nxt_o = mem_nxt[REG_CCR].ccr; // lets the engine copy stay in step
    assign sta_1_o   = mem_q[REG_STA].raw[1];

    // combinational read ports
    assign bus_rdata_o   = bus_rd_valid_i ? mem_q[bus_rd_idx_i].raw : '0;
    assign perip_rdata_o = mem_q[perip_rd_idx_i].raw;

endmodule

//--- verilog/usb_regs_top.sv
`timescale 1ns/1ps

module usb_regs_top import usb_regs_pkg::*; #(
    parameter int unsigned     SIZE        = DEF_SIZE,
    parameter logic [SIZE-1:0] ALLOW_WRITE = DEF_ALLOW_WRITE
) (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  bus_req_t    bus_i,
    output logic [31:0] bus_rdata_o,
    output logic        bus_err_o,
    input  logic        sof_i,
    input  logic [1:0]  sta_i,
    output logic        irq_o
);

    bus_wr_t     bus_wr;
    logic [1:0]  bus_rd_idx;
    logic        bus_rd_valid;

    perip_wr_t   perip_wr;
    logic [1:0]  perip_rd_idx;
    logic [31:0] frame;
    ccr_t        ccr_nxt;
    logic        sta_1;

    usb_bus_port #(
        .SIZE        (SIZE),
        .ALLOW_WRITE (ALLOW_WRITE)
    ) i_bus_port (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .bus_i      (bus_i),
        .wr_o       (bus_wr),
        .rd_idx_o   (bus_rd_idx),
        .rd_valid_o (bus_rd_valid),
        .bus_err_o  (bus_err_o)
    );

    usb_sof_engine i_sof_engine (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .sof_i     (sof_i),
        .ccr_nxt_i (ccr_nxt),
        .sta_1_i   (sta_1),
        .frame_i   (frame),
        .perip_o   (perip_wr),
        .rd_idx_o  (perip_rd_idx),
        .irq_o     (irq_o)
    );

    usb_mem #(
        .SIZE        (SIZE),
        .ALLOW_WRITE (ALLOW_WRITE)
    ) i_mem (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .bus_wr_i       (bus_wr),
        .bus_rd_idx_i   (bus_rd_idx),
        .bus_rd_valid_i (bus_rd_valid),
        .bus_rdata_o    (bus_rdata_o),
        .perip_i        (perip_wr),
        .perip_rd_idx_i (perip_rd_idx),
        .perip_rdata_o  (frame),        // engine only reads the frame counter
        .ccr_nxt_o      (ccr_nxt),
        .sta_i          (sta_i),
        .sta_1_o        (sta_1)
    );

endmodule

//--- tb/usb_regs_props.sv
`timescale 1ns/1ps

module usb_regs_props import usb_regs_pkg::*; (
    input logic        clk_i,
    input logic        rst_n_i,
    input logic        bus_err_i,
    input logic        irq_i,
    input logic        irq_en_i,   // stored control register field
    input logic        sta_1_i,    // stored status bit 1
    input perip_wr_t   perip_i,
    input logic [31:0] frame_i
);

    int unsigned fail_cnt = 0;

    // once set, the error flag holds until reset
    bus_err_sticky: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        bus_err_i |=> bus_err_i
    ) else begin
        $error("bus_err_o fell without a reset");
        fail_cnt++;
    end

    irq_registered: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        irq_i == $past(irq_en_i & sta_1_i)
    ) else begin
        $error("irq_o is not the previous cycle's irq_en AND status bit 1");
        fail_cnt++;
    end

    // only the engine moves the frame counter
    frame_engine_only: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        !(perip_i.we && perip_i.idx == REG_FRAME) |=> $stable(frame_i)
    ) else begin
        $error("frame counter changed without an engine write");
        fail_cnt++;
    end

endmodule

//--- tb/tb_usb_regs.sv
`timescale 1ns/1ps

module tb_usb_regs import usb_regs_pkg::*; ();

    localparam logic [31:0] ADDR_CCR     = 32'h0;
    localparam logic [31:0] ADDR_FRAME   = 32'h4;
    localparam logic [31:0] ADDR_SCRATCH = 32'h8;
    localparam logic [31:0] ADDR_STA     = 32'hc;
    localparam logic [31:0] ADDR_OOR     = 32'h10; // word index 4 is one past the last register

    logic        clk;
    logic        rst_n;
    bus_req_t    bus;
    logic [31:0] bus_rdata;
    logic        bus_err;
    logic        sof;
    logic [1:0]  sta;
    logic        irq;

    integer      seed;
    logic [31:0] shadow [4]; // expected register contents

    usb_regs_top #(
        .SIZE        (DEF_SIZE),
        .ALLOW_WRITE (DEF_ALLOW_WRITE)
    ) i_dut (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .bus_i       (bus),
        .bus_rdata_o (bus_rdata),
        .bus_err_o   (bus_err),
        .sof_i       (sof),
        .sta_i       (sta),
        .irq_o       (irq)
    );

    bind usb_regs_top usb_regs_props i_props (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .bus_err_i (bus_err_o),
        .irq_i     (irq_o),
        .irq_en_i  (i_mem.mem_q[0].ccr.irq_en),
        .sta_1_i   (sta_1),
        .perip_i   (perip_wr),
        .frame_i   (frame)
    );

    always #10 clk = ~clk;

    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("=== FAIL ===");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        stop_with_error($sformatf("** Error: %s = 0x%08h, expected 0x%08h", name, got, exp));
    endtask

    // old word with the enabled bytes replaced
    function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                                input logic [3:0] be);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                res[b*8 +: 8] = data[b*8 +: 8];
            end
        end
        return res;
    endfunction

    task automatic next_cycle();
        @(negedge clk);
        bus.we = 1'b0;
    endtask

    // write strobe stays up until the next task moves to the following falling edge
    task automatic bus_write(input logic [31:0] addr, input logic [3:0] be,
                             input logic [31:0] data);
        next_cycle();
        bus.we    = 1'b1;
        bus.be    = be;
        bus.addr  = addr;
        bus.wdata = data;
    endtask

    task automatic check_read(input logic [31:0] addr, input logic [31:0] exp,
                              input string name);
        logic [31:0] got;
        next_cycle();
        bus.addr = addr;
        #1;
        got = bus_rdata;
        assert (got == exp) else report_mismatch(name, got, exp);
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        assert (got === exp) else report_mismatch(name, 32'(got), 32'(exp));
    endtask

    task automatic sof_pulse(input int unsigned gap);
        next_cycle();
        sof = 1'b1;
        next_cycle();
        sof = 1'b0;
        repeat (gap) next_cycle();
    endtask

    task automatic wait_irq(input logic level, input string what);
        int unsigned cycles;
        cycles = 0;
        while (irq !== level) begin
            if (cycles == 6) begin
                stop_with_error({"irq_o did not ", what, " within six cycles"});
            end
            next_cycle();
            cycles++;
        end
    endtask

    always @(negedge clk) begin
        if (i_dut.i_props.fail_cnt != 0) begin
            stop_with_error("a concurrent property in usb_regs_props failed");
        end
    end

    initial begin
        int unsigned n;
        logic [31:0] data;
        logic [31:0] expv;
        logic [3:0]  be;
        logic [1:0]  s;
        logic        done;

        seed  = 32'h62eb;
        clk   = 1'b0;
        rst_n = 1'b0;
        bus   = '0;
        sof   = 1'b0;
        sta   = 2'b00;
        for (int i = 0; i < 4; i++) begin
            shadow[i] = '0;
        end

        repeat (16) @(negedge clk);
        rst_n = 1'b1;

        for (int i = 0; i < 4; i++) begin
            check_read(32'(i * 4), 32'h0, "bus_rdata_o after reset");
        end
        check_flag("bus_err_o", bus_err, 1'b0);
        check_flag("irq_o", irq, 1'b0);
        check_flag("perip_wr.we", i_dut.perip_wr.we, 1'b0);

        // byte-enabled scratch writes
        repeat (8) begin
            data = $random(seed);
            be   = 4'($random(seed));
            bus_write(ADDR_SCRATCH, be, data);
            shadow[REG_SCRATCH] = merge_bytes(shadow[REG_SCRATCH], data, be);
            check_read(ADDR_SCRATCH, shadow[REG_SCRATCH], "bus_rdata_o (scratch)");
        end

        // read-only frame counter and a dropped out-of-range write
        data = $random(seed);
        bus_write(ADDR_FRAME, 4'hf, data);
        check_read(ADDR_FRAME, shadow[REG_FRAME], "bus_rdata_o (frame)");
        bus_write(ADDR_OOR, 4'hf, data);
        check_read(ADDR_OOR, 32'h0, "bus_rdata_o (out of range)");
        check_flag("bus_err_o", bus_err, 1'b1);
        for (int i = 0; i < 3; i++) begin
            check_read(32'(i * 4), shadow[i], "bus_rdata_o after out-of-range write");
        end
        check_flag("bus_err_o", bus_err, 1'b1);

        // status follows sta_i one cycle late
        s = 2'b00;
        repeat (6) begin
            s = 2'($random(seed));
            next_cycle();
            sta = s;
            check_read(ADDR_STA, {30'b0, s}, "bus_rdata_o (status)");
        end
        data      = $random(seed);
        be        = 4'($random(seed));
        be[0]     = 1'b1;
        data[1:0] = ~s; // written bits differ from the sampled status
        bus_write(ADDR_STA, be, data);
        check_read(ADDR_STA, merge_bytes({30'b0, s}, data, be), "bus_rdata_o (status written)");
        check_read(ADDR_STA, {30'b0, s}, "bus_rdata_o (status resampled)");
        next_cycle();
        sta = 2'b00;

        // frame counting enabled and then disabled
        bus_write(ADDR_CCR, 4'hf, 32'h1);
        shadow[REG_CCR] = 32'h1;
        n = 3 + ($unsigned($random(seed)) % 4);
        repeat (n) begin
            sof_pulse(1 + ($unsigned($random(seed)) % 2));
        end
        shadow[REG_FRAME] = shadow[REG_FRAME] + n;
        check_read(ADDR_FRAME, shadow[REG_FRAME], "bus_rdata_o (frame count)");
        bus_write(ADDR_CCR, 4'hf, 32'h0);
        shadow[REG_CCR] = 32'h0;
        repeat (3) sof_pulse(1);
        check_read(ADDR_FRAME, shadow[REG_FRAME], "bus_rdata_o (frame, counting off)");

        // clear sequence with random reserved bits
        data      = $random(seed);
        data[2:0] = 3'b011;
        bus_write(ADDR_CCR, 4'hf, data);
        expv = data & ~32'h2;
        done = 1'b0;
        for (int k = 0; k < 3 && !done; k++) begin
            next_cycle();
            bus.addr = ADDR_CCR;
            #1;
            done = (bus_rdata[1] == 1'b0);
        end
        if (!done) begin
            stop_with_error("clear bit of the control register still set three cycles later");
        end
        assert (bus_rdata == expv)
            else report_mismatch("bus_rdata_o (control after clear)", bus_rdata, expv);
        shadow[REG_CCR]   = expv;
        shadow[REG_FRAME] = 32'h0;
        check_read(ADDR_FRAME, shadow[REG_FRAME], "bus_rdata_o (frame after clear)");

        // interrupt needs irq_en and status bit 1
        bus_write(ADDR_CCR, 4'hf, 32'h4);
        next_cycle();
        sta = 2'b10;
        wait_irq(1'b1, "rise");
        next_cycle();
        sta = 2'b00;
        wait_irq(1'b0, "fall after status bit 1 dropped");
        next_cycle();
        sta = 2'b10;
        wait_irq(1'b1, "rise again");
        bus_write(ADDR_CCR, 4'hf, 32'h0);
        wait_irq(1'b0, "fall after irq_en cleared");

        repeat (2) next_cycle();
        if (i_dut.i_props.fail_cnt != 0) begin
            stop_with_error("a concurrent property in usb_regs_props failed");
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

//--- tb.f
verilog/usb_regs_pkg.sv
verilog/usb_bus_port.sv
verilog/usb_sof_engine.sv
verilog/usb_mem.sv
verilog/usb_regs_top.sv
tb/usb_regs_props.sv
tb/tb_usb_regs.sv

//--- Bender.yml
package:
  name: usb_regs

dependencies: {}

sources:
  - verilog/usb_regs_pkg.sv
  - verilog/usb_bus_port.sv
  - verilog/usb_sof_engine.sv
  - verilog/usb_mem.sv
  - verilog/usb_regs_top.sv
  - target: test
    files:
      - tb/usb_regs_props.sv
      - tb/tb_usb_regs.sv
